// File: src/pmem_switch_macros.svh
`ifndef PMEM_SWITCH_MACROS_SVH
`define PMEM_SWITCH_MACROS_SVH

// number of stream ports, each both an input and an output
`define PORT_COUNT 4

// index of a port
`define PORT_BITS 2

// packet memory address, 256 beats per input
`define ADDR_WIDTH 8

// per-port packet tag, wraps after 16 packets
`define TAG_WIDTH 4

// packet length in beats, 63 max
`define LEN_WIDTH 6

// transmit command queue entries per output
`define CMDQ_DEPTH 4

`endif

// File: src/stream_pkg.sv
`default_nettype none

package stream_pkg;

	// payload word of one beat
	typedef logic [63:0] word_t;

	// unused bytes in the last beat of a packet
	typedef logic [2:0] empty_t;

	// one beat on a packet stream
	// empty only meaningful with eop
	typedef struct packed {
		word_t  data;
		logic   sop;
		logic   eop;
		empty_t empty;
	} beat_t;

endpackage

`default_nettype wire

// File: src/switch_pkg.sv
`default_nettype none

`include "pmem_switch_macros.svh"

package switch_pkg;

	typedef logic [`TAG_WIDTH-1:0]  tag_t;
	typedef logic [`PORT_BITS-1:0]  port_t;
	typedef logic [`ADDR_WIDTH-1:0] addr_t;
	typedef logic [`LEN_WIDTH-1:0]  len_t;

	// where a stored packet lives, 17 bits
	typedef struct packed {
		addr_t      start;
		len_t       length;
		logic [2:0] empty;
	} desc_t;

	// classifier result, layout of tagin_data
	typedef struct packed {
		port_t out_port;
		port_t in_port;
		tag_t  tag;
	} match_t;

	// queued at an output, 19 bits
	typedef struct packed {
		port_t src;
		desc_t desc;
	} cmd_t;

endpackage

`default_nettype wire

// File: src/input_port.sv
`default_nettype none

`include "pmem_switch_macros.svh"

module input_port (
	input  logic                   clock,
	input  logic                   reset,
	// incoming packet stream
	input  stream_pkg::beat_t      in_beat,
	input  logic                   in_valid,
	input  logic                   in_ready,
	// tag of the packet currently arriving
	output switch_pkg::tag_t       tag,
	// one read port per output
	input  logic [`ADDR_WIDTH-1:0] rd_addr [`PORT_COUNT],
	output logic [63:0]            rd_data [`PORT_COUNT],
	// descriptor lookup for the dispatcher
	input  switch_pkg::tag_t       lookup_tag,
	output switch_pkg::desc_t      lookup_desc
);
	import switch_pkg::*;

	logic  wr_en;
	logic  eop_en;
	addr_t wr_addr;
	addr_t start_addr;
	len_t  length;
	desc_t new_desc;

	// packet storage, one word per beat
	logic [63:0] mem [2**`ADDR_WIDTH];
	// indexed by tag, rewritten when the tag comes round again
	desc_t desc_mem [2**`TAG_WIDTH];

	assign wr_en  = in_valid && in_ready;
	assign eop_en = wr_en && in_beat.eop;

	// single-beat packet has its start in wr_addr, not yet latched
	assign new_desc.start  = in_beat.sop ? wr_addr : start_addr;
	assign new_desc.length = length;
	assign new_desc.empty  = in_beat.empty;

	// write address runs freely, wraps at the top of memory
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_addr    <= '0;
			start_addr <= '0;
		end else if (wr_en) begin
			wr_addr <= wr_addr + 1'b1;
			if (in_beat.sop) begin
				start_addr <= wr_addr;
			end
		end
	end

	// beats in the packet so far, includes the current one
	always_ff @(posedge clock) begin
		if (reset) begin
			length <= len_t'(1);
			tag    <= '0;
		end else if (eop_en) begin
			length <= len_t'(1);
			tag    <= tag + 1'b1;
		end else if (wr_en) begin
			length <= length + 1'b1;
		end
	end

	// memory write, plus a registered read for every output
	always_ff @(posedge clock) begin
		if (wr_en) begin
			mem[wr_addr] <= in_beat.data;
		end
		for (int p = 0; p < `PORT_COUNT; p++) begin
			rd_data[p] <= mem[rd_addr[p]];
		end
	end

	// descriptor written on eop, readable the cycle after
	always_ff @(posedge clock) begin
		if (eop_en) begin
			desc_mem[tag] <= new_desc;
		end
		lookup_desc <= desc_mem[lookup_tag];
	end

endmodule

`default_nettype wire

// File: src/match_dispatch.sv
`default_nettype none

`include "pmem_switch_macros.svh"

module match_dispatch (
	input  logic              clock,
	input  logic              reset,
	// match results from the classifier
	input  switch_pkg::match_t match,
	input  logic              match_valid,
	output logic              match_ready,
	// tag broadcast to every descriptor table
	output switch_pkg::tag_t  lookup_tag,
	input  switch_pkg::desc_t lookup_desc [`PORT_COUNT],
	// command to the output queues
	output logic              push [`PORT_COUNT],
	output switch_pkg::cmd_t  cmd,
	input  logic              cmdq_nearly_full [`PORT_COUNT]
);
	import switch_pkg::*;

	logic  stage_valid;
	port_t stage_in;
	port_t stage_out;

	// tables read every cycle, result used only after an accept
	assign lookup_tag = match.tag;

	// room for this match and the one in the stage register
	always_comb begin
		match_ready = 1'b1;
		for (int p = 0; p < `PORT_COUNT; p++) begin
			if (cmdq_nearly_full[p]) begin
				match_ready = 1'b0;
			end
		end
	end

	// hold the ports while the descriptor read completes
	always_ff @(posedge clock) begin
		if (reset) begin
			stage_valid <= 1'b0;
		end else begin
			stage_valid <= match_valid && match_ready;
		end
		stage_in  <= match.in_port;
		stage_out <= match.out_port;
	end

	// descriptor of the source input, tagged with its port
	assign cmd = {stage_in, lookup_desc[stage_in]};

	// one-hot strobe to the named output
	always_comb begin
		for (int p = 0; p < `PORT_COUNT; p++) begin
			push[p] = stage_valid && (stage_out == port_t'(p));
		end
	end

endmodule

`default_nettype wire

// File: src/transmit_port.sv
`default_nettype none

`include "pmem_switch_macros.svh"

module transmit_port (
	input  logic                   clock,
	input  logic                   reset,
	// commands from the dispatcher
	input  logic                   push,
	input  switch_pkg::cmd_t       cmd,
	output logic                   nearly_full,
	// read port into every input memory
	output logic [`ADDR_WIDTH-1:0] rd_addr,
	input  logic [63:0]            rd_data [`PORT_COUNT],
	// outgoing packet stream
	output stream_pkg::beat_t      out_beat,
	output logic                   out_valid,
	input  logic                   out_ready
);
	import switch_pkg::*;
	import stream_pkg::*;

	localparam int PTR_W = $clog2(`CMDQ_DEPTH);
	localparam logic [PTR_W:0] Q_LIMIT = `CMDQ_DEPTH - 2;

	cmd_t             q_mem [`CMDQ_DEPTH];
	logic [PTR_W-1:0] q_wr_ptr;
	logic [PTR_W-1:0] q_rd_ptr;
	logic [PTR_W:0]   q_count;
	cmd_t             q_head;
	logic             pop;

	addr_t      cur_addr;
	len_t       remaining;
	port_t      cur_src;
	empty_t     cur_empty;
	logic       cur_first;
	logic       active;
	logic       issue;

	logic       rd_pending;
	port_t      rd_src;
	logic       rd_sop;
	logic       rd_eop;
	empty_t     rd_empty;
	beat_t      rd_beat;

	beat_t      obuf [2];
	logic [1:0] buf_cnt;
	logic       buf_head;
	logic       out_pop;

	// command FIFO, fewer than two free slots stops the classifier
	assign q_head      = q_mem[q_rd_ptr];
	assign nearly_full = q_count > Q_LIMIT;

	always_ff @(posedge clock) begin
		if (push) begin
			q_mem[q_wr_ptr] <= cmd;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			q_wr_ptr <= '0;
			q_rd_ptr <= '0;
			q_count  <= '0;
		end else begin
			if (push) begin
				q_wr_ptr <= q_wr_ptr + 1'b1;
			end
			if (pop) begin
				q_rd_ptr <= q_rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   q_count <= q_count + 1'b1;
				2'b01:   q_count <= q_count - 1'b1;
				default: q_count <= q_count;
			endcase
		end
	end

	// next command only once the last beat has been issued
	assign active = remaining != '0;
	assign pop    = !active && (q_count != '0);
	// credit rule: buffered plus in-flight beats below two
	assign issue   = active && ((buf_cnt + {1'b0, rd_pending}) < 2'd2);
	assign rd_addr = cur_addr;

	// address wraps 255 to 0 by overflow
	always_ff @(posedge clock) begin
		if (reset) begin
			remaining <= '0;
			cur_first <= 1'b0;
		end else if (pop) begin
			cur_addr  <= q_head.desc.start;
			remaining <= q_head.desc.length;
			cur_src   <= q_head.src;
			cur_empty <= q_head.desc.empty;
			cur_first <= 1'b1;
		end else if (issue) begin
			cur_addr  <= cur_addr + 1'b1;
			remaining <= remaining - 1'b1;
			cur_first <= 1'b0;
		end
	end

	// sideband follows the read by one clock, like the memory data
	always_ff @(posedge clock) begin
		if (reset) begin
			rd_pending <= 1'b0;
		end else begin
			rd_pending <= issue;
		end
		rd_src   <= cur_src;
		rd_sop   <= cur_first;
		rd_eop   <= remaining == len_t'(1);
		rd_empty <= (remaining == len_t'(1)) ? cur_empty : '0;
	end

	// pick the source memory's word
	assign rd_beat.data  = rd_data[rd_src];
	assign rd_beat.sop   = rd_sop;
	assign rd_beat.eop   = rd_eop;
	assign rd_beat.empty = rd_empty;

	// two-entry output buffer, holds steady under back-pressure
	assign out_valid = buf_cnt != 2'd0;
	assign out_beat  = obuf[buf_head];
	assign out_pop   = out_valid && out_ready;

	always_ff @(posedge clock) begin
		if (rd_pending) begin
			obuf[buf_head ^ buf_cnt[0]] <= rd_beat;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			buf_cnt  <= 2'd0;
			buf_head <= 1'b0;
		end else begin
			if (out_pop) begin
				buf_head <= ~buf_head;
			end
			case ({rd_pending, out_pop})
				2'b10:   buf_cnt <= buf_cnt + 1'b1;
				2'b01:   buf_cnt <= buf_cnt - 1'b1;
				default: buf_cnt <= buf_cnt;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/pmem_switch.sv
`default_nettype none

`include "pmem_switch_macros.svh"

module pmem_switch (
	input  logic                    clock,
	input  logic                    reset,
	// streams from the interfaces
	input  logic [63:0]             packetin_data [`PORT_COUNT],
	input  logic                    packetin_valid [`PORT_COUNT],
	input  logic                    packetin_sop [`PORT_COUNT],
	input  logic                    packetin_eop [`PORT_COUNT],
	input  logic [2:0]              packetin_empty [`PORT_COUNT],
	output logic                    packetin_ready [`PORT_COUNT],
	// tagged copy for the classifier, tag above the data
	output logic [`TAG_WIDTH+63:0]  packetout_data [`PORT_COUNT],
	output logic                    packetout_valid [`PORT_COUNT],
	output logic                    packetout_sop [`PORT_COUNT],
	output logic                    packetout_eop [`PORT_COUNT],
	input  logic                    packetout_ready [`PORT_COUNT],
	// switched output streams
	output logic [63:0]             transmitout_data [`PORT_COUNT],
	output logic                    transmitout_valid [`PORT_COUNT],
	output logic                    transmitout_sop [`PORT_COUNT],
	output logic                    transmitout_eop [`PORT_COUNT],
	output logic [2:0]              transmitout_empty [`PORT_COUNT],
	input  logic                    transmitout_ready [`PORT_COUNT],
	// match results
	input  switch_pkg::match_t      tagin_data,
	input  logic                    tagin_valid,
	output logic                    tagin_ready
);
	import stream_pkg::*;
	import switch_pkg::*;

	beat_t in_beat [`PORT_COUNT];
	tag_t  tag [`PORT_COUNT];
	beat_t tx_beat [`PORT_COUNT];
	desc_t lookup_desc [`PORT_COUNT];
	tag_t  lookup_tag;
	cmd_t  cmd;
	logic  push [`PORT_COUNT];
	logic  nearly_full [`PORT_COUNT];

	// read address per output, data as [input][output] and transposed
	logic [`ADDR_WIDTH-1:0] tx_rd_addr [`PORT_COUNT];
	logic [63:0]            mem_rd_data [`PORT_COUNT][`PORT_COUNT];
	logic [63:0]            tx_rd_data [`PORT_COUNT][`PORT_COUNT];

	for (genvar i = 0; i < `PORT_COUNT; i++) begin : g_in
		// passthrough, ready comes from the classifier side
		assign packetin_ready[i]  = packetout_ready[i];
		assign packetout_data[i]  = {tag[i], packetin_data[i]};
		assign packetout_valid[i] = packetin_valid[i];
		assign packetout_sop[i]   = packetin_sop[i];
		assign packetout_eop[i]   = packetin_eop[i];

		assign in_beat[i] = '{
			data:  packetin_data[i],
			sop:   packetin_sop[i],
			eop:   packetin_eop[i],
			empty: packetin_empty[i]
		};

		input_port input_port_i (
			.clock       (clock),
			.reset       (reset),
			.in_beat     (in_beat[i]),
			.in_valid    (packetin_valid[i]),
			.in_ready    (packetout_ready[i]),
			.tag         (tag[i]),
			.rd_addr     (tx_rd_addr),
			.rd_data     (mem_rd_data[i]),
			.lookup_tag  (lookup_tag),
			.lookup_desc (lookup_desc[i])
		);

		for (genvar j = 0; j < `PORT_COUNT; j++) begin : g_xpose
			assign tx_rd_data[j][i] = mem_rd_data[i][j];
		end
	end

	match_dispatch match_dispatch_i (
		.clock            (clock),
		.reset            (reset),
		.match            (tagin_data),
		.match_valid      (tagin_valid),
		.match_ready      (tagin_ready),
		.lookup_tag       (lookup_tag),
		.lookup_desc      (lookup_desc),
		.push             (push),
		.cmd              (cmd),
		.cmdq_nearly_full (nearly_full)
	);

	for (genvar j = 0; j < `PORT_COUNT; j++) begin : g_out
		transmit_port transmit_port_i (
			.clock       (clock),
			.reset       (reset),
			.push        (push[j]),
			.cmd         (cmd),
			.nearly_full (nearly_full[j]),
			.rd_addr     (tx_rd_addr[j]),
			.rd_data     (tx_rd_data[j]),
			.out_beat    (tx_beat[j]),
			.out_valid   (transmitout_valid[j]),
			.out_ready   (transmitout_ready[j])
		);

		assign transmitout_data[j]  = tx_beat[j].data;
		assign transmitout_sop[j]   = tx_beat[j].sop;
		assign transmitout_eop[j]   = tx_beat[j].eop;
		assign transmitout_empty[j] = tx_beat[j].empty;
	end

endmodule

`default_nettype wire

// File: sim/pmem_switch_tb.sv
`default_nettype none

`include "pmem_switch_macros.svh"

module pmem_switch_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_ROWS = 14;

	// one packet with its destinations as a mask of outputs
	typedef struct packed {
		logic [1:0] in_port;
		logic [3:0] out_mask;
		logic [5:0] len;
		logic [2:0] empty;
		logic       stall;
	} row_t;

	// out0 collects rows from several inputs in match order
	// port 0 rows run past address 255 on row ten
	localparam row_t ROWS [NUM_ROWS] = '{
		'{2'd0, 4'b0001, 6'd1,  3'd5, 1'b0},
		'{2'd1, 4'b0100, 6'd8,  3'd3, 1'b0},
		'{2'd2, 4'b1010, 6'd12, 3'd7, 1'b0},
		'{2'd3, 4'b0001, 6'd20, 3'd0, 1'b1},
		'{2'd0, 4'b0001, 6'd63, 3'd2, 1'b0},
		'{2'd1, 4'b0001, 6'd63, 3'd1, 1'b0},
		'{2'd0, 4'b0001, 6'd63, 3'd4, 1'b0},
		'{2'd0, 4'b0010, 6'd63, 3'd6, 1'b0},
		'{2'd0, 4'b0001, 6'd63, 3'd3, 1'b0},
		'{2'd0, 4'b0100, 6'd40, 3'd1, 1'b0},
		'{2'd3, 4'b1111, 6'd10, 3'd2, 1'b1},
		'{2'd2, 4'b1000, 6'd30, 3'd5, 1'b1},
		'{2'd1, 4'b1000, 6'd5,  3'd0, 1'b1},
		'{2'd0, 4'b0010, 6'd16, 3'd7, 1'b1}
	};

	logic                   clock;
	logic                   reset;
	logic [63:0]            packetin_data [`PORT_COUNT];
	logic                   packetin_valid [`PORT_COUNT];
	logic                   packetin_sop [`PORT_COUNT];
	logic                   packetin_eop [`PORT_COUNT];
	logic [2:0]             packetin_empty [`PORT_COUNT];
	logic                   packetin_ready [`PORT_COUNT];
	logic [`TAG_WIDTH+63:0] packetout_data [`PORT_COUNT];
	logic                   packetout_valid [`PORT_COUNT];
	logic                   packetout_sop [`PORT_COUNT];
	logic                   packetout_eop [`PORT_COUNT];
	logic                   packetout_ready [`PORT_COUNT];
	logic [63:0]            transmitout_data [`PORT_COUNT];
	logic                   transmitout_valid [`PORT_COUNT];
	logic                   transmitout_sop [`PORT_COUNT];
	logic                   transmitout_eop [`PORT_COUNT];
	logic [2:0]             transmitout_empty [`PORT_COUNT];
	logic                   transmitout_ready [`PORT_COUNT];
	switch_pkg::match_t     tagin_data;
	logic                   tagin_valid;
	logic                   tagin_ready;

	// expected output beats as {data, sop, eop, empty}
	logic [68:0] exp_q [`PORT_COUNT][$];
	// words and tag of the packet last sent
	logic [63:0] pkt_words [$];
	logic [3:0]  pkt_tag;
	logic [31:0] data_lfsr;
	logic [31:0] stall_lfsr;
	logic        stall_on;
	int          tag_count [`PORT_COUNT];
	int          errors;
	int          checks;

	pmem_switch pmem_switch_i (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// galois form with taps of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h8020_0003;
		end
		return state >> 1;
	endfunction

	// one lfsr step per data bit
	task automatic random_word(output logic [63:0] word);
		for (int i = 0; i < 64; i++) begin
			word[i]   = data_lfsr[0];
			data_lfsr = lfsr_step(data_lfsr);
		end
	endtask

	task automatic report_mismatch(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		errors++;
		$display("Fail %0t %s expected %0h got %0h", $time, name, expected, actual);
	endtask

	function automatic int beats_left();
		int total;
		total = 0;
		for (int j = 0; j < `PORT_COUNT; j++) begin
			total += exp_q[j].size();
		end
		return total;
	endfunction

	// one beat per clock with the tagged copy checked on every beat
	task automatic send_packet(input row_t row);
		logic [63:0] word;
		logic        last;
		int          port;
		port    = int'(row.in_port);
		pkt_tag = 4'(tag_count[port] % 16);
		pkt_words.delete();
		for (int b = 0; b < int'(row.len); b++) begin
			random_word(word);
			pkt_words.push_back(word);
			last = (b == int'(row.len) - 1);
			@(negedge clock);
			packetin_data[port]  = word;
			packetin_valid[port] = 1'b1;
			packetin_sop[port]   = (b == 0);
			packetin_eop[port]   = last;
			packetin_empty[port] = last ? row.empty : 3'd0;
			@(posedge clock);
			checks++;
			if (packetout_data[port] !== {pkt_tag, word}) begin
				report_mismatch($sformatf("packetout_data[%0d]", port),
					128'({pkt_tag, word}), 128'(packetout_data[port]));
			end
			checks++;
			if ({packetin_ready[port], packetout_valid[port], packetout_sop[port],
					packetout_eop[port]} !== {2'b11, b == 0, last}) begin
				report_mismatch($sformatf("ready/valid/sop/eop[%0d]", port),
					128'({2'b11, b == 0, last}),
					128'({packetin_ready[port], packetout_valid[port],
					packetout_sop[port], packetout_eop[port]}));
			end
		end
		@(negedge clock);
		packetin_valid[port] = 1'b0;
		packetin_sop[port]   = 1'b0;
		packetin_eop[port]   = 1'b0;
		tag_count[port]++;
	endtask

	// expected beats queued once the dispatcher takes the match
	task automatic send_match(input row_t row, input int out_port);
		logic last;
		@(negedge clock);
		tagin_data.out_port = 2'(out_port);
		tagin_data.in_port  = row.in_port;
		tagin_data.tag      = pkt_tag;
		tagin_valid         = 1'b1;
		do begin
			@(posedge clock);
		end while (tagin_ready !== 1'b1);
		for (int b = 0; b < int'(row.len); b++) begin
			last = (b == int'(row.len) - 1);
			exp_q[out_port].push_back({pkt_words[b], b == 0, last, last ? row.empty : 3'd0});
		end
		@(negedge clock);
		tagin_valid = 1'b0;
	endtask

	// ready toggled by lfsr bits while the current row stalls
	initial begin
		stall_lfsr = 32'hf5d9_1836;
		for (int j = 0; j < `PORT_COUNT; j++) begin
			transmitout_ready[j] = 1'b1;
		end
		forever begin
			@(negedge clock);
			for (int j = 0; j < `PORT_COUNT; j++) begin
				if (stall_on) begin
					transmitout_ready[j] = stall_lfsr[0];
					stall_lfsr           = lfsr_step(stall_lfsr);
				end else begin
					transmitout_ready[j] = 1'b1;
				end
			end
		end
	end

	// each accepted beat must be the next one expected
	always @(posedge clock) begin
		logic [68:0] expected;
		logic [68:0] actual;
		for (int j = 0; j < `PORT_COUNT; j++) begin
			if (!reset && transmitout_valid[j] && transmitout_ready[j]) begin
				actual = {transmitout_data[j], transmitout_sop[j], transmitout_eop[j],
					transmitout_empty[j]};
				checks++;
				if (exp_q[j].size() == 0) begin
					errors++;
					$display("output %0d sent a beat that no match asked for at %0t", j, $time);
				end else begin
					expected = exp_q[j].pop_front();
					if (actual !== expected) begin
						report_mismatch($sformatf("transmitout[%0d] {data,sop,eop,empty}", j),
							128'(expected), 128'(actual));
					end
				end
			end
		end
	end

	// limit scales with the table and allows for slow stalled beats
	initial begin
		int cycles;
		cycles = 16 + 200;
		for (int i = 0; i < NUM_ROWS; i++) begin
			cycles += int'(ROWS[i].len) * 16 + 40;
		end
		#(cycles * 10);
		$display("timeout after %0d cycles, outputs did not drain", cycles);
		$display("checks %0d errors %0d", checks, errors);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		reset       = 1'b1;
		tagin_valid = 1'b0;
		tagin_data  = '0;
		stall_on    = 1'b0;
		data_lfsr   = 32'hf5d9_1836;
		errors      = 0;
		checks      = 0;
		for (int p = 0; p < `PORT_COUNT; p++) begin
			packetin_data[p]   = '0;
			packetin_valid[p]  = 1'b0;
			packetin_sop[p]    = 1'b0;
			packetin_eop[p]    = 1'b0;
			packetin_empty[p]  = '0;
			packetout_ready[p] = 1'b1;
			tag_count[p]       = 0;
		end
		repeat (16) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		// classifier side held off while the inputs are idle
		for (int p = 0; p < `PORT_COUNT; p++) begin
			packetout_ready[p] = 1'b0;
		end
		// idle state straight after reset
		@(posedge clock);
		for (int j = 0; j < `PORT_COUNT; j++) begin
			checks++;
			if (transmitout_valid[j] !== 1'b0) begin
				report_mismatch($sformatf("transmitout_valid[%0d]", j), 128'(0),
					128'(transmitout_valid[j]));
			end
		end
		checks++;
		if (tagin_ready !== 1'b1) begin
			report_mismatch("tagin_ready", 128'(1), 128'(tagin_ready));
		end
		// ready and valid follow the other side of the passthrough
		for (int p = 0; p < `PORT_COUNT; p++) begin
			checks++;
			if ({packetin_ready[p], packetout_valid[p]} !== 2'b00) begin
				report_mismatch($sformatf("packetin_ready/packetout_valid[%0d]", p),
					128'(0), 128'({packetin_ready[p], packetout_valid[p]}));
			end
		end
		@(negedge clock);
		for (int p = 0; p < `PORT_COUNT; p++) begin
			packetout_ready[p] = 1'b1;
		end
		for (int i = 0; i < NUM_ROWS; i++) begin
			@(posedge clock);
			stall_on = ROWS[i].stall;
			send_packet(ROWS[i]);
			for (int j = 0; j < `PORT_COUNT; j++) begin
				if (ROWS[i].out_mask[j]) begin
					send_match(ROWS[i], j);
				end
			end
		end
		while (beats_left() != 0) begin
			@(posedge clock);
		end
		// quiet tail so that any extra beat shows up in the scoreboard
		repeat (20) @(posedge clock);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: pmem_switch.f
+incdir+src
src/stream_pkg.sv
src/switch_pkg.sv
src/input_port.sv
src/match_dispatch.sv
src/transmit_port.sv
src/pmem_switch.sv
sim/pmem_switch_tb.sv

// File: Makefile
SIM      := verilator
SIMFLAGS := --binary --timing --Wno-fatal
TOP      := pmem_switch_tb
FILELIST := pmem_switch.f

OBJDIR  := obj_dir
BIN     := $(OBJDIR)/V$(TOP)
LOG     := sim.log
SOURCES := $(shell grep -v '^+' $(FILELIST)) src/pmem_switch_macros.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TESTS PASSED" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
